// File: rtl/counter_pkg.sv
package counter_pkg;

    // Chain geometry
    localparam int NUM_DIGITS = 4;
    localparam int DIGIT_W    = 4;
    localparam int INDEX_W    = 2;   // log2 of NUM_DIGITS
    localparam int SPEED_W    = 5;
    localparam int SEG_W      = 7;

    // Rate divider counter width covers the default base period
    localparam int STEP_CNT_W = 32;

    localparam logic [STEP_CNT_W-1:0] STEP_BASE_DEFAULT = 32'd100_000_000;
    localparam int SCAN_BITS_DEFAULT = 17;

    // Top values of one digit in each mode
    localparam logic [DIGIT_W-1:0] DEC_MAX = 4'd9;
    localparam logic [DIGIT_W-1:0] HEX_MAX = 4'hf;

    typedef enum logic
    {
        mode_decimal = 1'b0,
        mode_hex     = 1'b1
    } count_mode_e;

    typedef enum logic
    {
        dir_up   = 1'b0,
        dir_down = 1'b1
    } count_dir_e;

    // d0 is the ones digit
    typedef struct packed
    {
        logic [DIGIT_W-1:0] d3;
        logic [DIGIT_W-1:0] d2;
        logic [DIGIT_W-1:0] d1;
        logic [DIGIT_W-1:0] d0;
    } digits_t;

    typedef struct packed
    {
        logic [SEG_W-1:0]      sseg;  // Active high, segment a in bit 0
        logic [NUM_DIGITS-1:0] an;    // Active low
    } display_t;

    typedef struct packed
    {
        count_mode_e mode;
        count_dir_e  dir;
    } count_ctrl_t;

endpackage

// File: rtl/rate_divider.sv
`timescale 1ns/10ps

module rate_divider
#(
    parameter logic [counter_pkg::STEP_CNT_W-1:0] step_base = counter_pkg::STEP_BASE_DEFAULT
)
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic [counter_pkg::SPEED_W-1:0] speed,
    output logic                            step
);

    logic [counter_pkg::STEP_CNT_W-1:0] limit;
    logic [counter_pkg::STEP_CNT_W-1:0] count_q;

    // Higher speed gives a shorter period
    assign limit = step_base >> speed;

    // A lowered limit steps on the same cycle the count passes it
    assign step = (count_q >= limit);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            count_q <= '0;
        end
        else if (step)
        begin
            count_q <= '0;
        end
        else
        begin
            count_q <= count_q + 1'b1;
        end
    end

    // After a step the count restarts at zero, so back-to-back steps need limit 0
    step_spacing_a: assert property (
        @(posedge clk) disable iff (reset)
        step |=> (limit == '0 || !step)
    )
    else $error("rate_divider: step high on two cycles in a row with limit %0d", limit);

endmodule

// File: rtl/digit_counter.sv
`timescale 1ns/10ps

module digit_counter
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cnt_en,
    input  counter_pkg::count_ctrl_t        ctrl,
    output logic [counter_pkg::DIGIT_W-1:0] digit,
    output logic                            terminal
);

    logic [counter_pkg::DIGIT_W-1:0] max_val;
    logic [counter_pkg::DIGIT_W-1:0] digit_inc;
    logic [counter_pkg::DIGIT_W-1:0] digit_dec;
    logic [counter_pkg::DIGIT_W-1:0] digit_next;
    logic                            is_decimal;
    logic                            is_up;

    assign is_decimal = (ctrl.mode == counter_pkg::mode_decimal);
    assign is_up      = (ctrl.dir == counter_pkg::dir_up);

    assign max_val   = is_decimal ? counter_pkg::DEC_MAX : counter_pkg::HEX_MAX;
    assign digit_inc = digit + 1'b1;   // Wraps F to 0 by width
    assign digit_dec = digit - 1'b1;

    // A decimal digit above 9 is never terminal going up
    assign terminal = is_up ? (digit == max_val) : (digit == '0);

    always_comb
    begin
        if (is_up)
        begin
            if (is_decimal && digit >= counter_pkg::DEC_MAX)
                digit_next = '0;   // Wrap, or out-of-range value back to 0
            else
                digit_next = digit_inc;
        end
        else
        begin
            if (digit == '0)
                digit_next = max_val;
            else if (is_decimal && digit > counter_pkg::DEC_MAX)
                digit_next = counter_pkg::DEC_MAX;
            else
                digit_next = digit_dec;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            digit <= '0;
        end
        else if (cnt_en)
        begin
            digit <= digit_next;
        end
    end

    // Hex mode moves by exactly one modulo 16 per counted cycle
    hex_no_skip_a: assert property (
        @(posedge clk) disable iff (reset)
        (cnt_en && ctrl.mode == counter_pkg::mode_hex)
            |=> (digit == $past(digit_inc) || digit == $past(digit_dec))
    )
    else $error("digit_counter: hex digit skipped a value, now %h", digit);

endmodule

// File: rtl/segment_decoder.sv
`timescale 1ns/10ps

module segment_decoder
(
    input  logic [counter_pkg::DIGIT_W-1:0] value,
    output logic [counter_pkg::SEG_W-1:0]   sseg
);

    // Bit order g f e d c b a
    always_comb
    begin
        case (value)
            4'h0: sseg = 7'h3f;
            4'h1: sseg = 7'h06;
            4'h2: sseg = 7'h5b;
            4'h3: sseg = 7'h4f;
            4'h4: sseg = 7'h66;
            4'h5: sseg = 7'h6d;
            4'h6: sseg = 7'h7d;
            4'h7: sseg = 7'h07;
            4'h8: sseg = 7'h7f;
            4'h9: sseg = 7'h6f;
            4'ha: sseg = 7'h77;
            4'hb: sseg = 7'h7c;   // Lower case b
            4'hc: sseg = 7'h39;
            4'hd: sseg = 7'h5e;   // Lower case d
            4'he: sseg = 7'h79;
            4'hf: sseg = 7'h71;
            default: sseg = 7'h00;
        endcase
    end

endmodule

// File: rtl/display_scanner.sv
`timescale 1ns/10ps

module display_scanner
#(
    parameter int scan_bits = counter_pkg::SCAN_BITS_DEFAULT
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  counter_pkg::digits_t  digits,
    output counter_pkg::display_t disp
);

    logic [scan_bits-1:0]               scan_q;
    logic                               scan_wrap;
    logic [counter_pkg::INDEX_W-1:0]    index_q;
    logic [counter_pkg::DIGIT_W-1:0]    sel_digit;
    logic [counter_pkg::SEG_W-1:0]      seg_code;
    logic [counter_pkg::NUM_DIGITS-1:0] an_sel;

    assign scan_wrap = &scan_q;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            scan_q  <= '0;
            index_q <= '0;
        end
        else
        begin
            scan_q <= scan_q + 1'b1;
            if (scan_wrap)
                index_q <= index_q + 1'b1;
        end
    end

    always_comb
    begin
        case (index_q)
            2'd0: sel_digit = digits.d0;
            2'd1: sel_digit = digits.d1;
            2'd2: sel_digit = digits.d2;
            default: sel_digit = digits.d3;
        endcase
    end

    // One-hot select that is inverted for the active-low anodes
    always_comb
    begin
        an_sel          = '0;
        an_sel[index_q] = 1'b1;
    end

    segment_decoder u_decoder
    (
        .value (sel_digit),
        .sseg  (seg_code)
    );

    assign disp = '{sseg: seg_code, an: ~an_sel};

    one_anode_low_a: assert property (
        @(posedge clk) disable iff (reset)
        $onehot(~disp.an)
    )
    else $error("display_scanner: anode pattern %b is not one-cold", disp.an);

endmodule

// File: rtl/counter_display_top.sv
`timescale 1ns/10ps

module counter_display_top
#(
    parameter logic [counter_pkg::STEP_CNT_W-1:0] step_base = counter_pkg::STEP_BASE_DEFAULT,
    parameter int scan_bits = counter_pkg::SCAN_BITS_DEFAULT
)
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            enable,
    input  counter_pkg::count_ctrl_t        ctrl,
    input  logic [counter_pkg::SPEED_W-1:0] speed,
    output counter_pkg::display_t           disp
);

    logic                                                   step;
    logic [counter_pkg::NUM_DIGITS-1:0]                     carry;     // Count enable per digit
    logic [counter_pkg::NUM_DIGITS-1:0]                     terminal;
    logic [counter_pkg::NUM_DIGITS-1:0][counter_pkg::DIGIT_W-1:0] digit_arr;
    counter_pkg::digits_t                                   digits;

    rate_divider #(.step_base(step_base)) u_divider
    (
        .clk   (clk),
        .reset (reset),
        .speed (speed),
        .step  (step)
    );

    assign carry[0] = step & enable;

    generate
        for (genvar i = 0; i < counter_pkg::NUM_DIGITS; i++)
        begin : g_digit
            digit_counter u_digit
            (
                .clk      (clk),
                .reset    (reset),
                .cnt_en   (carry[i]),
                .ctrl     (ctrl),
                .digit    (digit_arr[i]),
                .terminal (terminal[i])
            );

            // A digit counts only when every lower digit is terminal
            if (i < counter_pkg::NUM_DIGITS - 1)
            begin : g_carry
                assign carry[i+1] = carry[i] & terminal[i];
            end
        end
    endgenerate

    assign digits = digit_arr;   // Index 3 lands on d3

    display_scanner #(.scan_bits(scan_bits)) u_scanner
    (
        .clk    (clk),
        .reset  (reset),
        .digits (digits),
        .disp   (disp)
    );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// File: tests/counter_display_tb.sv
`timescale 1ns/10ps

module counter_display_tb;

    localparam logic [31:0] STEP_BASE = 32'd16;
    localparam int SCAN_BITS = 2;

    // Run length with the directed part first
    localparam int DIRECTED_CYCLES = 1000;
    localparam int RANDOM_CYCLES   = 5000;
    localparam int TIMEOUT_CYCLES  = DIRECTED_CYCLES + RANDOM_CYCLES + 2000;

    logic                            clk;
    logic                            reset;
    logic                            enable;
    counter_pkg::count_ctrl_t        ctrl;
    logic [counter_pkg::SPEED_W-1:0] speed;
    counter_pkg::display_t           disp;

    // Model state
    logic [31:0]          div_count;
    logic [3:0]           m_dig [counter_pkg::NUM_DIGITS];
    logic [SCAN_BITS-1:0] m_scan;
    logic [1:0]           m_index;

    logic [31:0] lfsr_state = 32'h0f4fd23d;
    string       test_name;
    int          checks = 0;
    int          an_errors = 0;
    int          seg_errors = 0;
    int          step_errors = 0;
    int          count_errors = 0;
    int          cycle_count = 0;

    tb_clock_gen u_clock
    (
        .clk   (clk),
        .reset (reset)
    );

    counter_display_top #(.step_base(STEP_BASE), .scan_bits(SCAN_BITS)) UUT
    (
        .clk    (clk),
        .reset  (reset),
        .enable (enable),
        .ctrl   (ctrl),
        .speed  (speed),
        .disp   (disp)
    );

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic int digit_base(input counter_pkg::count_ctrl_t c);
        return (c.mode == counter_pkg::mode_hex) ? 16 : 10;
    endfunction

    function automatic logic is_terminal(input logic [3:0] d, input counter_pkg::count_ctrl_t c);
        if (c.dir == counter_pkg::dir_up)
            return int'(d) == digit_base(c) - 1;
        return d == 4'd0;
    endfunction

    function automatic logic [3:0] next_digit(input logic [3:0] d,
                                              input counter_pkg::count_ctrl_t c);
        int base;
        int v;
        base = digit_base(c);
        v = int'(d);
        if (v >= base)
            v = (c.dir == counter_pkg::dir_up) ? 0 : base - 1;   // Decimal digit above 9
        else if (c.dir == counter_pkg::dir_up)
            v = (v + 1) % base;
        else
            v = (v + base - 1) % base;
        return 4'(v);
    endfunction

    // Segments gfedcba
    function automatic logic [6:0] seg_code(input logic [3:0] d);
        case (d)
            4'h0: return 7'b0111111;
            4'h1: return 7'b0000110;
            4'h2: return 7'b1011011;
            4'h3: return 7'b1001111;
            4'h4: return 7'b1100110;
            4'h5: return 7'b1101101;
            4'h6: return 7'b1111101;
            4'h7: return 7'b0000111;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1101111;
            4'ha: return 7'b1110111;
            4'hb: return 7'b1111100;
            4'hc: return 7'b0111001;
            4'hd: return 7'b1011110;
            4'he: return 7'b1111001;
            default: return 7'b1110001;
        endcase
    endfunction

    function automatic logic [15:0] model_value();
        return {m_dig[3], m_dig[2], m_dig[1], m_dig[0]};
    endfunction

    task automatic check_outputs();
        logic [3:0] exp_an;
        logic [6:0] exp_seg;
        logic       exp_step;
        exp_an   = ~(4'b0001 << m_index);
        exp_seg  = seg_code(m_dig[m_index]);
        exp_step = div_count >= (STEP_BASE >> speed);
        checks   = checks + 3;
        assert (disp.an == exp_an)
        else
        begin
            an_errors++;
            $display("error %s: anode expected %b actual %b", test_name, exp_an, disp.an);
        end
        assert (disp.sseg == exp_seg)
        else
        begin
            seg_errors++;
            $display("error %s: segments expected %b actual %b", test_name, exp_seg, disp.sseg);
        end
        assert (UUT.u_divider.step == exp_step)
        else
        begin
            step_errors++;
            $display("error %s: step expected %b actual %b", test_name, exp_step,
                     UUT.u_divider.step);
        end
    endtask

    // One clock edge of the model and then the check just after it
    task automatic tick();
        logic step_now;
        logic chain;
        logic term;
        @(posedge clk);
        step_now = div_count >= (STEP_BASE >> speed);
        div_count = step_now ? 32'd0 : div_count + 32'd1;
        chain = step_now & enable;
        for (int i = 0; i < counter_pkg::NUM_DIGITS; i++)
        begin
            term = is_terminal(m_dig[i], ctrl);
            if (chain)
                m_dig[i] = next_digit(m_dig[i], ctrl);
            chain = chain & term;   // Carry into the next digit
        end
        m_scan = m_scan + 1'b1;
        if (m_scan == '0)
            m_index = m_index + 1'b1;
        #1;
        check_outputs();
    endtask

    task automatic run_until(input logic [15:0] target, input int max_cycles);
        int n;
        n = 0;
        while (model_value() != target && n < max_cycles)
        begin
            tick();
            n++;
        end
        checks++;
        assert (UUT.digits == target)
        else
        begin
            count_errors++;
            $display("error %s: count expected %h actual %h", test_name, target, UUT.digits);
        end
    endtask

    // Each input holds its value for its own random span
    task automatic random_phase(input int cycles);
        int          hold_mode;
        int          hold_dir;
        int          hold_en;
        int          hold_speed;
        logic [31:0] bits;
        hold_mode  = 0;
        hold_dir   = 0;
        hold_en    = 0;
        hold_speed = 0;
        repeat (cycles)
        begin
            if (hold_mode == 0)
            begin
                bits = take_bits(1);
                ctrl.mode = counter_pkg::count_mode_e'(bits[0]);
                hold_mode = 1 + take_bits(7);
            end
            if (hold_dir == 0)
            begin
                bits = take_bits(1);
                ctrl.dir = counter_pkg::count_dir_e'(bits[0]);
                hold_dir = 1 + take_bits(7);
            end
            if (hold_en == 0)
            begin
                bits = take_bits(2);
                enable = (bits[1:0] != 2'b00);
                hold_en = 1 + take_bits(5);
            end
            if (hold_speed == 0)
            begin
                bits = take_bits(5);
                speed = bits[4:0];
                hold_speed = 1 + take_bits(6);
            end
            hold_mode--;
            hold_dir--;
            hold_en--;
            hold_speed--;
            tick();
        end
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    initial
    begin
        enable    = 1'b1;
        ctrl.mode = counter_pkg::mode_decimal;
        ctrl.dir  = counter_pkg::dir_up;
        speed     = 5'd4;   // Limit 1 gives a step every 2 cycles
        div_count = '0;
        m_scan    = '0;
        m_index   = '0;
        for (int i = 0; i < counter_pkg::NUM_DIGITS; i++)
            m_dig[i] = 4'd0;
        @(negedge reset);

        test_name = "reset";
        check_outputs();

        test_name = "dec_up";
        run_until(16'h0099, 300);
        run_until(16'h0100, 3);

        test_name = "dec_down_wrap";
        speed = 5'd31;
        ctrl.dir = counter_pkg::dir_down;
        run_until(16'h0000, 200);
        run_until(16'h9999, 3);
        ctrl.dir = counter_pkg::dir_up;
        run_until(16'h0000, 3);

        test_name = "hex_wrap";
        ctrl.mode = counter_pkg::mode_hex;
        ctrl.dir = counter_pkg::dir_down;
        run_until(16'hffff, 3);
        ctrl.dir = counter_pkg::dir_up;
        run_until(16'h0000, 3);

        test_name = "preset";
        run_until(16'h0123, 400);
        run_until(16'h01ab, 200);

        test_name = "dec_over9_up";
        ctrl.mode = counter_pkg::mode_decimal;
        run_until(16'h01a0, 3);
        run_until(16'h0100, 20);

        test_name = "dec_over9_down";
        ctrl.mode = counter_pkg::mode_hex;
        ctrl.dir = counter_pkg::dir_down;
        run_until(16'h00ff, 3);
        ctrl.mode = counter_pkg::mode_decimal;
        run_until(16'h00f9, 3);
        run_until(16'h0099, 20);

        test_name = "enable_hold";
        speed = 5'd3;
        enable = 1'b0;
        repeat (23) tick();
        enable = 1'b1;
        run_until(16'h0090, 200);

        test_name = "random";
        random_phase(RANDOM_CYCLES);

        $display("checks %0d, anode errors %0d, seg errors %0d, step errors %0d, count errors %0d",
                 checks, an_errors, seg_errors, step_errors, count_errors);
        if (an_errors + seg_errors + step_errors + count_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: build.f
rtl/counter_pkg.sv
rtl/rate_divider.sv
rtl/digit_counter.sv
rtl/segment_decoder.sv
rtl/display_scanner.sv
rtl/counter_display_top.sv
tests/tb_clock_gen.sv
tests/counter_display_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the counter display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module counter_display_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcounter_display_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
